// ==== hw/controlPkg.sv ====
`default_nettype none

package controlPkg;

    //**************************************************************************
    // widths and timing

    localparam int instrWidth = 16;
    localparam int delayWidth = 6;
    localparam logic [delayWidth-1:0] startDelay = 6'd40; // cycles in start before first PC write
    localparam logic [3:0] stackPtrLow = 4'd14;           // low byte of the SP pair

    localparam logic [3:0] aluPassA = 4'd14;
    localparam logic [3:0] aluPassB = 4'd0;

    //**************************************************************************
    // opcodes, low three bits
    localparam logic [2:0] opIn  = 3'b010;
    localparam logic [2:0] opOut = 3'b100;
    localparam logic [2:0] opLdi = 3'b000; // immediate ALU code in bits 3..1

    // opcodes, bits 7..3 with the low three bits zero
    localparam logic [4:0] opMov        = 5'b01001;
    localparam logic [4:0] opStoreFirst = 5'b01110; // plain, post-inc, post-dec follow
    localparam logic [4:0] opLoadFirst  = 5'b10001;
    localparam logic [4:0] opIrp        = 5'b10100;
    localparam logic [4:0] opDrp        = 5'b10101;
    localparam logic [4:0] opJmpi       = 5'b10110;
    localparam logic [4:0] opJmp        = 5'b10111;
    localparam logic [4:0] opCall       = 5'b11000;
    localparam logic [4:0] opRet        = 5'b11001;
    localparam logic [4:0] opHlt        = 5'b11110;

    // condition codes in bits 15..13
    localparam logic [2:0] condAlways   = 3'b000;
    localparam logic [2:0] condCarry    = 3'b001;
    localparam logic [2:0] condNoCarry  = 3'b010;
    localparam logic [2:0] condZero     = 3'b011;
    localparam logic [2:0] condNotZero  = 3'b100;
    localparam logic [2:0] condNeg      = 3'b101;
    localparam logic [2:0] condNotNeg   = 3'b110;
    localparam logic [2:0] condAlwaysHi = 3'b111;

    //**************************************************************************
    // types

    typedef logic [instrWidth-1:0] instrWordT;
    typedef logic [3:0] aluModeT;
    typedef logic [3:0] regSelT;

    typedef enum logic [3:0] {
        aluImm, aluReg, portIn, portOut,
        memStore, memLoad, pairUpdate,
        jumpIndTaken, jumpTaken, callTaken, retTaken,
        skipAddress,  // JMP or CALL failed, step over the address word
        skipBranch,   // JMPI or RET failed
        halt, noOp
    } instrClassT;

    typedef enum logic [1:0] {keep, inc, dec} pairStepT;

    typedef enum logic [2:0] {
        start, execute, second, third, jumpTarget, callTarget
    } seqStateT;

    typedef enum logic [1:0] {aluOut = 2'd0, dMemOut = 2'd2} regSrcT;

    typedef enum logic [1:0] {regB = 2'd0, imm8 = 2'd2} aluSrcBT;

    typedef enum logic [2:0] {
        dataPcPlusOneHigh = 3'd0,
        dataPcPlusOneLow  = 3'd1,
        dataAluOut        = 3'd2
    } dMemDataT;

    typedef enum logic [1:0] {
        addrRegPair        = 2'd0,
        addrPort           = 2'd1, // zero-extended bits 11..4
        addrRegPairPlusOne = 2'd2
    } dMemAddrT;

    typedef enum logic [2:0] {
        pcPlusOne    = 3'd0,
        pcOut        = 3'd1,
        pcIMemOut    = 3'd3, // address word just fetched
        pcRegPair    = 3'd4,
        pcReturnAddr = 3'd5
    } pcSrcT;

endpackage

`default_nettype wire

// ==== hw/controlSignalGen.sv ====
`default_nettype none

module controlSignalGen (
    input  wire controlPkg::instrClassT instrClass,
    input  wire controlPkg::seqStateT   seqState,
    input  wire controlPkg::aluModeT    aluModeField,
    input  wire controlPkg::regSelT     regBField,
    input  wire controlPkg::pairStepT   pairStep,
    input  wire                         writesFlags,
    input  wire                         startRelease,
    output controlPkg::regSrcT          regFileSrc,
    output controlPkg::regSelT          regFileOutBSelect,
    output logic                        regFileWriteEnable,
    output logic                        regFileIncPair,
    output logic                        regFileDecPair,
    output controlPkg::aluSrcBT         aluSrcBSelect,
    output controlPkg::aluModeT         aluMode,
    output controlPkg::dMemDataT        dMemDataSelect,
    output controlPkg::dMemAddrT        dMemIOAddressSelect,
    output logic                        dMemIOWriteEn,
    output logic                        dMemIOReadEn,
    output logic                        flagEnable,
    output controlPkg::pcSrcT           iMemAddrSelect,
    output logic                        iMemReadEnable,
    output logic                        pcWriteEn
);
    import controlPkg::*;

    logic isReadBack;

    assign isReadBack = (instrClass == portIn) || (instrClass == memLoad);

    always_comb begin
        regFileSrc          = aluOut;
        regFileOutBSelect   = regBField;
        regFileWriteEnable  = 1'b0;
        regFileIncPair      = 1'b0;
        regFileDecPair      = 1'b0;
        aluSrcBSelect       = regB;
        aluMode             = aluModeField;
        dMemDataSelect      = dataAluOut;
        dMemIOAddressSelect = addrRegPair;
        dMemIOWriteEn       = 1'b0;
        dMemIOReadEn        = 1'b0;
        flagEnable          = 1'b0;
        iMemAddrSelect      = pcOut;
        iMemReadEnable      = 1'b0;
        pcWriteEn           = 1'b0;

        case (seqState)
            start: begin
                aluMode        = aluPassB;
                iMemReadEnable = 1'b1;
                pcWriteEn      = startRelease;              // single pulse at the end of the wait
            end

            //******************************************************************
            // first cycle of every instruction
            execute: begin
                pcWriteEn      = 1'b1;                      // most classes finish here
                iMemReadEnable = 1'b1;
                case (instrClass)
                    aluImm: begin
                        regFileWriteEnable = 1'b1;
                        aluSrcBSelect      = imm8;
                        flagEnable         = writesFlags;
                    end
                    aluReg: begin
                        regFileWriteEnable = 1'b1;
                        flagEnable         = writesFlags;
                    end
                    portIn: begin
                        regFileSrc          = dMemOut;
                        dMemIOAddressSelect = addrPort;
                        dMemIOReadEn        = 1'b1;
                        pcWriteEn           = 1'b0;
                        iMemReadEnable      = 1'b0;
                    end
                    portOut: begin
                        dMemIOAddressSelect = addrPort;
                        dMemIOWriteEn       = 1'b1;
                    end
                    memStore, memLoad, pairUpdate: begin
                        regFileIncPair = (pairStep == inc);
                        regFileDecPair = (pairStep == dec);
                        dMemIOWriteEn  = (instrClass == memStore);
                        if (instrClass == memLoad) begin
                            regFileSrc     = dMemOut;
                            dMemIOReadEn   = 1'b1;
                            pcWriteEn      = 1'b0;
                            iMemReadEnable = 1'b0;
                        end
                    end
                    jumpIndTaken: iMemAddrSelect = pcRegPair;
                    skipAddress:  iMemAddrSelect = pcPlusOne; // step over the address word
                    callTaken: begin
                        regFileOutBSelect = stackPtrLow;
                        dMemDataSelect    = dataPcPlusOneLow;
                        dMemIOWriteEn     = 1'b1;
                        regFileDecPair    = 1'b1;
                        pcWriteEn         = 1'b0;     // target not read yet
                    end
                    retTaken: begin
                        regFileOutBSelect   = stackPtrLow;
                        dMemIOAddressSelect = addrRegPairPlusOne;
                        dMemIOReadEn        = 1'b1;   // pop high byte
                        regFileIncPair      = 1'b1;
                        pcWriteEn           = 1'b0;
                        iMemReadEnable      = 1'b0;
                    end
                    halt: begin
                        pcWriteEn      = 1'b0;
                        iMemReadEnable = 1'b0;
                    end
                    default: ;                        // jumpTaken, skipBranch, noOp
                endcase
            end

            //******************************************************************
            // follow-on cycles
            second: begin
                if (isReadBack) begin
                    regFileSrc          = dMemOut;
                    dMemIOAddressSelect = (instrClass == portIn) ? addrPort : addrRegPair;
                    regFileWriteEnable  = 1'b1;
                    pcWriteEn           = 1'b1;
                    iMemReadEnable      = 1'b1;
                end else begin
                    regFileOutBSelect   = stackPtrLow;
                    dMemIOAddressSelect = addrRegPairPlusOne;
                    dMemIOReadEn        = 1'b1;       // pop low byte
                    regFileIncPair      = 1'b1;
                    iMemAddrSelect      = pcReturnAddr;
                end
            end
            third: begin
                regFileOutBSelect = stackPtrLow;
                iMemAddrSelect    = pcReturnAddr;
                pcWriteEn         = 1'b1;
                iMemReadEnable    = 1'b1;
            end
            jumpTarget: begin
                iMemAddrSelect = pcIMemOut;
                pcWriteEn      = 1'b1;
                iMemReadEnable = 1'b1;
            end
            callTarget: begin
                regFileOutBSelect = stackPtrLow;  // decoder sees the address word now
                dMemDataSelect    = dataPcPlusOneHigh;
                dMemIOWriteEn     = 1'b1;
                regFileDecPair    = 1'b1;
                iMemAddrSelect    = pcIMemOut;
                pcWriteEn         = 1'b1;
                iMemReadEnable    = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/controlUnit.sv ====
`default_nettype none

module controlUnit (
    input  wire                          clk,
    input  wire                          reset,
    input  wire controlPkg::instrWordT   iMemOut,
    input  wire                          carryFlag,
    input  wire                          zeroFlag,
    input  wire                          negativeFlag,
    output controlPkg::regSrcT           regFileSrc,
    output controlPkg::regSelT           regFileOutBSelect,
    output logic                         regFileWriteEnable,
    output logic                         regFileIncPair,
    output logic                         regFileDecPair,
    output controlPkg::aluSrcBT          aluSrcBSelect,
    output controlPkg::aluModeT          aluMode,
    output controlPkg::dMemDataT         dMemDataSelect,
    output controlPkg::dMemAddrT         dMemIOAddressSelect,
    output logic                         dMemIOWriteEn,
    output logic                         dMemIOReadEn,
    output logic                         flagEnable,
    output controlPkg::pcSrcT            iMemAddrSelect,
    output logic                         iMemReadEnable,
    output logic                         pcWriteEn
);
    import controlPkg::*;

    instrClassT instrClass;
    aluModeT    aluModeField;
    regSelT     regBField;
    pairStepT   pairStep;
    logic       writesFlags;
    seqStateT   seqState;
    logic       startRelease;

    // decode, sequence, drive
    instrDecoder i_instrDecoder (
        .iMemOut      (iMemOut),
        .carryFlag    (carryFlag),
        .zeroFlag     (zeroFlag),
        .negativeFlag (negativeFlag),
        .instrClass   (instrClass),
        .aluModeField (aluModeField),
        .regBField    (regBField),
        .pairStep     (pairStep),
        .writesFlags  (writesFlags)
    );

    cycleSequencer i_cycleSequencer (
        .clk          (clk),
        .reset        (reset),
        .instrClass   (instrClass),
        .seqState     (seqState),
        .startRelease (startRelease)
    );

    controlSignalGen i_controlSignalGen (
        .instrClass          (instrClass),
        .seqState            (seqState),
        .aluModeField        (aluModeField),
        .regBField           (regBField),
        .pairStep            (pairStep),
        .writesFlags         (writesFlags),
        .startRelease        (startRelease),
        .regFileSrc          (regFileSrc),
        .regFileOutBSelect   (regFileOutBSelect),
        .regFileWriteEnable  (regFileWriteEnable),
        .regFileIncPair      (regFileIncPair),
        .regFileDecPair      (regFileDecPair),
        .aluSrcBSelect       (aluSrcBSelect),
        .aluMode             (aluMode),
        .dMemDataSelect      (dMemDataSelect),
        .dMemIOAddressSelect (dMemIOAddressSelect),
        .dMemIOWriteEn       (dMemIOWriteEn),
        .dMemIOReadEn        (dMemIOReadEn),
        .flagEnable          (flagEnable),
        .iMemAddrSelect      (iMemAddrSelect),
        .iMemReadEnable      (iMemReadEnable),
        .pcWriteEn           (pcWriteEn)
    );

endmodule

`default_nettype wire

// ==== hw/cycleSequencer.sv ====
`default_nettype none

module cycleSequencer (
    input  wire                         clk,
    input  wire                         reset,
    input  wire controlPkg::instrClassT instrClass,
    output controlPkg::seqStateT        seqState,
    output logic                        startRelease
);
    import controlPkg::*;

    logic [delayWidth-1:0] delay;
    seqStateT              nextState;

    assign startRelease = (seqState == start) && (delay == startDelay);

    //**************************************************************************
    // state and startup counter

    always_ff @(posedge clk) begin
        if (reset) begin
            seqState <= start;
            delay    <= '0;
        end else begin
            seqState <= nextState;
            if (seqState == start)
                delay <= delay + 1'b1; // stops counting once out of start
        end
    end

    always_comb begin
        nextState = execute;
        case (seqState)
            start: begin
                nextState = startRelease ? execute : start;
            end
            execute: begin
                case (instrClass)
                    portIn, memLoad, retTaken: nextState = second;
                    jumpTaken:                 nextState = jumpTarget;
                    callTaken:                 nextState = callTarget;
                    default:                   nextState = execute; // halt parks here too
                endcase
            end
            second: begin
                // only RET has a third cycle
                if (instrClass == portIn || instrClass == memLoad)
                    nextState = execute;
                else
                    nextState = third;
            end
            default: begin
                nextState = execute;                        // third, jumpTarget, callTarget
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/instrDecoder.sv ====
`default_nettype none

module instrDecoder (
    input  wire controlPkg::instrWordT   iMemOut,
    input  wire                          carryFlag,
    input  wire                          zeroFlag,
    input  wire                          negativeFlag,
    output controlPkg::instrClassT       instrClass,
    output controlPkg::aluModeT          aluModeField,
    output controlPkg::regSelT           regBField,
    output controlPkg::pairStepT         pairStep,
    output logic                         writesFlags
);
    import controlPkg::*;

    logic [4:0] op5;
    logic [2:0] op3;
    logic [4:0] memOffset;
    logic       condMet;
    logic       isImm;
    logic       isWide;
    logic       isRegOp;
    logic       isStore;
    logic       isLoad;

    assign op5 = iMemOut[7:3];
    assign op3 = iMemOut[2:0];

    assign isImm   = iMemOut[0] && (iMemOut[3:1] != 3'b111);
    assign isWide  = (op3 == 3'b000);                     // forms coded in bits 7..3
    assign isRegOp = isWide && (op5 != 5'd0) && (op5 < opStoreFirst);
    assign isStore = isWide && (op5 >= opStoreFirst) && (op5 < opLoadFirst);
    assign isLoad  = isWide && (op5 >= opLoadFirst) && (op5 < opIrp);

    assign memOffset = isStore ? (op5 - opStoreFirst) : (op5 - opLoadFirst);

    assign writesFlags = (isImm && (iMemOut[3:1] != opLdi)) || (isRegOp && (op5 != opMov));

    // branch condition
    always_comb begin
        case (iMemOut[15:13])
            condAlways, condAlwaysHi: condMet = 1'b1;
            condCarry:                condMet = carryFlag;
            condNoCarry:              condMet = ~carryFlag;
            condZero:                 condMet = zeroFlag;
            condNotZero:              condMet = ~zeroFlag;
            condNeg:                  condMet = negativeFlag;
            condNotNeg:               condMet = ~negativeFlag;
        endcase
    end

    //**************************************************************************
    // instruction class, failed branches fold into the skip classes

    always_comb begin
        instrClass = noOp;
        if (isImm)
            instrClass = aluImm;
        else if (op3 == opIn)
            instrClass = portIn;
        else if (op3 == opOut)
            instrClass = portOut;
        else if (isRegOp)
            instrClass = aluReg;
        else if (isStore)
            instrClass = memStore;
        else if (isLoad)
            instrClass = memLoad;
        else if (isWide) begin
            case (op5)
                opIrp, opDrp: instrClass = pairUpdate;
                opJmpi:       instrClass = condMet ? jumpIndTaken : skipBranch;
                opJmp:        instrClass = condMet ? jumpTaken : skipAddress;
                opCall:       instrClass = condMet ? callTaken : skipAddress;
                opRet:        instrClass = condMet ? retTaken : skipBranch;
                opHlt:        instrClass = halt;
                default:      instrClass = noOp; // PUS, POS, SSR, CSR and spare codes
            endcase
        end
    end

    // field extraction
    always_comb begin
        if (isImm)
            aluModeField = {1'b0, iMemOut[3:1]};
        else if (isRegOp)
            aluModeField = iMemOut[6:3];
        else if (isStore || isLoad || (isWide && op5 >= opIrp && op5 <= opJmp))
            aluModeField = aluPassA;
        else
            aluModeField = aluPassB;

        if (isWide && (op5 == opCall || op5 == opRet))
            regBField = stackPtrLow;
        else if (isWide && op5 != 5'd0 && op5 <= opJmpi)
            regBField = iMemOut[11:8];                   // SSSS or pair PPPP
        else
            regBField = iMemOut[15:12];

        pairStep = keep;
        if (isStore || isLoad) begin
            if (memOffset == 5'd1)
                pairStep = inc;
            else if (memOffset == 5'd2)
                pairStep = dec;
        end else if (isWide && op5 == opIrp)
            pairStep = inc;
        else if (isWide && op5 == opDrp)
            pairStep = dec;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/controlPkg.sv
hw/instrDecoder.sv
hw/cycleSequencer.sv
hw/controlSignalGen.sv
hw/controlUnit.sv
verif/controlUnitTb.sv

// ==== verif/controlCases.txt ====
# name instr c z n  regSrc outB we inc dec  srcB mode flagEn  dData dAddr dWr dRd  pcSrc iRd pcWr
# all fields hex, one line per clock cycle, lines of one test are consecutive
addImm         5A73 0 0 0  0 5 1 0 0  2 1 1  2 0 0 0  1 1 1
ldi            3421 0 0 0  0 3 1 0 0  2 0 0  2 0 0 0  1 1 1
aluReg         4718 0 0 0  0 7 1 0 0  0 3 1  2 0 0 0  1 1 1
mov            2648 0 0 0  0 6 1 0 0  0 9 0  2 0 0 0  1 1 1
portOut        9AB4 0 0 0  0 9 0 0 0  0 0 0  2 1 1 0  1 1 1
portIn         8C52 0 0 0  2 8 0 0 0  0 0 0  2 1 0 1  1 0 0
portIn         8C52 0 0 0  2 8 1 0 0  0 0 0  2 1 0 0  1 1 1
loadInc        0390 0 0 0  2 3 0 1 0  0 E 0  2 0 0 1  1 0 0
loadInc        0390 0 0 0  2 3 1 0 0  0 E 0  2 0 0 0  1 1 1
storeDec       0580 0 0 0  0 5 0 0 1  0 E 0  2 0 1 0  1 1 1
irp            07A0 0 0 0  0 7 0 1 0  0 E 0  2 0 0 0  1 1 1
drp            09A8 0 0 0  0 9 0 0 1  0 E 0  2 0 0 0  1 1 1
jmpZeroTaken   60B8 0 1 0  0 6 0 0 0  0 E 0  2 0 0 0  1 1 1
jmpZeroTaken   4000 0 1 0  0 4 0 0 0  0 0 0  2 0 0 0  3 1 1
jmpZeroSkip    60B8 0 0 0  0 6 0 0 0  0 E 0  2 0 0 0  0 1 1
jmpCarrySkip   20B8 0 1 1  0 2 0 0 0  0 E 0  2 0 0 0  0 1 1
jmpNotNegTaken C0B8 1 0 0  0 C 0 0 0  0 E 0  2 0 0 0  1 1 1
jmpNotNegTaken 4000 1 0 0  0 4 0 0 0  0 0 0  2 0 0 0  3 1 1
callTaken      00C0 0 0 0  0 E 0 0 1  0 0 0  1 0 1 0  1 1 0
callTaken      4000 0 0 0  0 E 0 0 1  0 0 0  0 0 1 0  3 1 1
callCarrySkip  20C0 0 0 0  0 E 0 0 0  0 0 0  2 0 0 0  0 1 1
jmpiTaken      6AB0 0 1 0  0 A 0 0 0  0 E 0  2 0 0 0  4 1 1
jmpiSkip       6AB0 0 0 0  0 A 0 0 0  0 E 0  2 0 0 0  1 1 1
retTaken       A0C8 0 0 1  0 E 0 1 0  0 0 0  2 2 0 1  1 0 0
retTaken       A0C8 0 0 1  0 E 0 1 0  0 0 0  2 2 0 1  5 0 0
retTaken       A0C8 0 0 1  0 E 0 0 0  0 0 0  2 0 0 0  5 1 1
retSkip        A0C8 0 0 0  0 E 0 0 0  0 0 0  2 0 0 0  1 1 1
halt           00F0 0 0 0  0 0 0 0 0  0 0 0  2 0 0 0  1 0 0
halt           00F0 0 0 0  0 0 0 0 0  0 0 0  2 0 0 0  1 0 0
halt           00F0 0 0 0  0 0 0 0 0  0 0 0  2 0 0 0  1 0 0

// ==== verif/controlUnitTb.sv ====
`default_nettype none

module controlUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    import controlPkg::*;

    logic       clk;
    logic       reset;
    instrWordT  iMemOut;
    logic       carryFlag;
    logic       zeroFlag;
    logic       negativeFlag;
    regSrcT     regFileSrc;
    regSelT     regFileOutBSelect;
    logic       regFileWriteEnable;
    logic       regFileIncPair;
    logic       regFileDecPair;
    aluSrcBT    aluSrcBSelect;
    aluModeT    aluMode;
    dMemDataT   dMemDataSelect;
    dMemAddrT   dMemIOAddressSelect;
    logic       dMemIOWriteEn;
    logic       dMemIOReadEn;
    logic       flagEnable;
    pcSrcT      iMemAddrSelect;
    logic       iMemReadEnable;
    logic       pcWriteEn;

    string      testName;
    logic       testFailed;
    int         testCycles;
    int         testCount;
    int         failCount;
    int         errorCount;
    int         cycle;
    logic       released;
    instrWordT  startWords [3];

    // one line of the case file with all columns in hex
    logic [15:0] word, cIn, zIn, nIn;
    logic [15:0] expSrc, expB, expWe, expInc, expDec;
    logic [15:0] expSrcB, expMode, expFlag;
    logic [15:0] expData, expAddr, expWr, expRd;
    logic [15:0] expPc, expIRd, expPcWr;

    controlUnit i_controlUnit (
        .clk(clk), .reset(reset), .iMemOut(iMemOut),
        .carryFlag(carryFlag), .zeroFlag(zeroFlag), .negativeFlag(negativeFlag),
        .regFileSrc(regFileSrc), .regFileOutBSelect(regFileOutBSelect),
        .regFileWriteEnable(regFileWriteEnable), .regFileIncPair(regFileIncPair),
        .regFileDecPair(regFileDecPair), .aluSrcBSelect(aluSrcBSelect), .aluMode(aluMode),
        .dMemDataSelect(dMemDataSelect), .dMemIOAddressSelect(dMemIOAddressSelect),
        .dMemIOWriteEn(dMemIOWriteEn), .dMemIOReadEn(dMemIOReadEn), .flagEnable(flagEnable),
        .iMemAddrSelect(iMemAddrSelect), .iMemReadEnable(iMemReadEnable),
        .pcWriteEn(pcWriteEn)
    );

    always #10 clk = ~clk; // 20 ns period

    task automatic noteFailure();
        errorCount++;
        testFailed = 1'b1;
    endtask

    //**************************************************************************
    // one compare task per output group

    task automatic checkRegFile(input string label, input regSrcT eSrc, input regSelT eB,
                                input logic [2:0] eEn);
        if (regFileSrc !== eSrc) begin
            $display("CHECK FAILED %s regFileSrc expected %0h actual %0h", label, eSrc,
                     regFileSrc);
            noteFailure();
        end
        if (regFileOutBSelect !== eB) begin
            $display("CHECK FAILED %s regFileOutBSelect expected %0h actual %0h", label, eB,
                     regFileOutBSelect);
            noteFailure();
        end
        if ({regFileWriteEnable, regFileIncPair, regFileDecPair} !== eEn) begin
            $display("CHECK FAILED %s write/inc/dec expected %b actual %b", label, eEn,
                     {regFileWriteEnable, regFileIncPair, regFileDecPair});
            noteFailure();
        end
    endtask

    task automatic checkAlu(input string label, input aluSrcBT eSrcB, input aluModeT eMode,
                            input logic eFlag);
        if (aluSrcBSelect !== eSrcB || aluMode !== eMode || flagEnable !== eFlag) begin
            $display("CHECK FAILED %s srcB/mode/flagEn expected %0h/%0h/%b actual %0h/%0h/%b",
                     label, eSrcB, eMode, eFlag, aluSrcBSelect, aluMode, flagEnable);
            noteFailure();
        end
    endtask

    task automatic checkMem(input string label, input dMemDataT eData, input dMemAddrT eAddr,
                            input logic [1:0] eEn);
        if (dMemDataSelect !== eData || dMemIOAddressSelect !== eAddr) begin
            $display("CHECK FAILED %s data/addr select expected %0h/%0h actual %0h/%0h",
                     label, eData, eAddr, dMemDataSelect, dMemIOAddressSelect);
            noteFailure();
        end
        if ({dMemIOWriteEn, dMemIOReadEn} !== eEn) begin
            $display("CHECK FAILED %s write/read expected %b actual %b", label, eEn,
                     {dMemIOWriteEn, dMemIOReadEn});
            noteFailure();
        end
    endtask

    task automatic checkFetch(input string label, input pcSrcT ePc, input logic eRead,
                              input logic ePcWrite);
        if (iMemAddrSelect !== ePc || iMemReadEnable !== eRead || pcWriteEn !== ePcWrite) begin
            $display("CHECK FAILED %s pcSrc/iRead/pcWrite expected %0h/%b/%b actual %0h/%b/%b",
                     label, ePc, eRead, ePcWrite, iMemAddrSelect, iMemReadEnable, pcWriteEn);
            noteFailure();
        end
    endtask

    task automatic finishTest();
        testCount++;
        if (testFailed) begin
            failCount++;
            $display("test %s failed after %0d cycles", testName, testCycles);
        end else begin
            $display("test %s passed in %0d cycles", testName, testCycles);
        end
        testName = "";
    endtask

    // drive on the falling edge and sample just before the rising edge
    task automatic applyCycle(input instrWordT w, input logic [2:0] flags);
        @(negedge clk);
        iMemOut = w;
        {carryFlag, zeroFlag, negativeFlag} = flags;
        #8;
    endtask

    task automatic checkLine(input string label);
        checkRegFile(label, regSrcT'(expSrc[1:0]), regSelT'(expB[3:0]),
                     {expWe[0], expInc[0], expDec[0]});
        checkAlu(label, aluSrcBT'(expSrcB[1:0]), aluModeT'(expMode[3:0]), expFlag[0]);
        checkMem(label, dMemDataT'(expData[2:0]), dMemAddrT'(expAddr[1:0]),
                 {expWr[0], expRd[0]});
        checkFetch(label, pcSrcT'(expPc[2:0]), expIRd[0], expPcWr[0]);
    endtask

    //**************************************************************************
    // case file with one line per clock cycle

    task automatic runCaseFile();
        int               fd;
        int               status;
        int               fields;
        int               lineNo;
        logic             atEnd;
        logic [8*160-1:0] lineBuf;
        logic [8*32-1:0]  nameBuf;
        logic [8*32-1:0]  firstTok;
        string            label;
        fd = $fopen("verif/controlCases.txt", "r");
        atEnd = 1'b0;
        if (fd == 0) begin
            $display("could not open verif/controlCases.txt");
            errorCount++;
        end else begin
            for (lineNo = 1; lineNo <= 400 && !atEnd; lineNo++) begin
                lineBuf = '0;
                status = $fgets(lineBuf, fd);
                if (status == 0) begin
                    atEnd = 1'b1;
                end else begin
                    firstTok = '0;
                    fields = $sscanf(lineBuf, "%s", firstTok);
                    if (fields == 1 && firstTok != "#") begin
                        fields = $sscanf(lineBuf,
                            "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            nameBuf, word, cIn, zIn, nIn, expSrc, expB, expWe, expInc, expDec,
                            expSrcB, expMode, expFlag, expData, expAddr, expWr, expRd,
                            expPc, expIRd, expPcWr);
                        if (fields != 20) begin
                            $display("case file line %0d has %0d fields, expected 20",
                                     lineNo, fields);
                            errorCount++;
                        end else begin
                            label = string'(nameBuf);
                            if (label != testName) begin
                                if (testName != "")
                                    finishTest();
                                testName   = label;
                                testFailed = 1'b0;
                                testCycles = 0;
                            end
                            applyCycle(word, {cIn[0], zIn[0], nIn[0]});
                            checkLine(label);
                            testCycles++;
                        end
                    end
                end
            end
            $fclose(fd);
            if (testName != "")
                finishTest();
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        iMemOut      = '0;  // decodes as NOP
        carryFlag    = 1'b0;
        zeroFlag     = 1'b0;
        negativeFlag = 1'b0;
        testCount    = 0;
        failCount    = 0;
        errorCount   = 0;
        released     = 1'b0;
        startWords[0] = 16'h0590; // load with post-increment
        startWords[1] = 16'h5A73; // immediate ADD
        startWords[2] = 16'h0580; // store with post-decrement
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // startup wait with the PC write due in cycle startDelay + 1
        testName   = "startup";
        testFailed = 1'b0;
        testCycles = 0;
        for (cycle = 1; cycle <= 100 && !released; cycle++) begin
            if (cycle > 1)
                @(negedge clk);
            iMemOut = startWords[cycle % 3]; // each word raises enables outside start
            #8;
            checkRegFile(testName, aluOut, 4'd5, 3'b000); // register field 5 in every word
            checkAlu(testName, regB, aluPassB, 1'b0);
            checkMem(testName, dataAluOut, addrRegPair, 2'b00);
            checkFetch(testName, pcOut, 1'b1, cycle == startDelay + 1);
            released = pcWriteEn;
            testCycles++;
        end

        if (!released) begin
            $display("pcWriteEn never rose within 100 cycles after reset");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            finishTest();
            runCaseFile();
            if (testCount < 2) begin
                $display("no cases were read from the case file");
                errorCount++;
            end
            $display("tests %0d, failed %0d, check errors %0d", testCount, failCount,
                     errorCount);
            if (errorCount == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
